/* source/valu_pkg.sv */
package valu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes

  // Data word and its byte enable
  localparam int unsigned ElenBits = 64;
  localparam int unsigned StrbBits = 8;

  // Queue depths and number of instruction ids
  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;
  localparam int unsigned NrVInsn          = 8;

  // Register file geometry
  localparam int unsigned VregWords = 8;
  localparam int unsigned MaxVl     = 64;

  //////////////////////////////////////////////////////////////////////
  // Basic types

  typedef logic [$clog2(MaxVl+1)-1:0] vl_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [4:0]                 vreg_t;
  // Register number times VregWords plus word index
  typedef logic [$bits(vreg_t)+$clog2(VregWords)-1:0] vaddr_t;
  typedef logic [ElenBits-1:0] elen_t;
  typedef logic [StrbBits-1:0] strb_t;

  // Element width, elements per word is 8 >> code
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  // Integer opcodes, compares unsigned and shift logical
  typedef enum logic [2:0] {
    VADD, VSUB, VAND, VOR, VXOR, VMINU, VMAXU, VSLL
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////
  // Transfer structs

  typedef struct packed {
    vid_t    id;
    alu_op_e op;
    vsew_e   vsew;
    vl_t     vl;
    vreg_t   vd;
    logic    use_scalar;
    elen_t   scalar;
    // Set means unmasked
    logic    vm;
  } valu_insn_t;

  typedef struct packed {
    elen_t a;
    elen_t b;
    strb_t mask;
  } operand_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_t;

  // Elements carried by one word, capped by what is left of the instruction
  function automatic vl_t word_elems(vsew_e vsew, vl_t left);
    vl_t per_word;
    per_word = vl_t'(StrbBits >> vsew);
    return (left < per_word) ? left : per_word;
  endfunction

endpackage

/* source/valu_simd_alu.sv */
`timescale 1ns/100ps

module valu_simd_alu import valu_pkg::*; (
  input  elen_t   opa_i,
  input  elen_t   opb_i,
  input  alu_op_e op_i,
  input  vsew_e   vsew_i,
  output elen_t   res_o
);

  // Full word result for each element width
  elen_t [3:0] res_w;

  //////////////////////////////////////////////////////////////////////
  // Lanes per element width

  // Width 8 << g, lanes never share a carry
  for (genvar g = 0; g < 4; g++) begin : gen_ew
    for (genvar l = 0; l < (ElenBits >> (3 + g)); l++) begin : gen_lane
      logic [(8 << g)-1:0] a;
      logic [(8 << g)-1:0] b;
      logic [(8 << g)-1:0] r;
      // Shift amount modulo the element width
      logic [2+g:0]        sh;

      assign a  = opa_i[(8 << g)*l +: (8 << g)];
      assign b  = opb_i[(8 << g)*l +: (8 << g)];
      assign sh = b[2+g:0];

      always_comb begin
        unique case (op_i)
          VADD:  r = a + b;
          VSUB:  r = a - b;
          VAND:  r = a & b;
          VOR:   r = a | b;
          VXOR:  r = a ^ b;
          // Unsigned compares
          VMINU: r = (a < b) ? a : b;
          VMAXU: r = (a > b) ? a : b;
          // Logical shift left
          VSLL:  r = a << sh;
        endcase
      end

      assign res_w[g][(8 << g)*l +: (8 << g)] = r;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Width select

  // Encoding of vsew matches the index of res_w
  assign res_o = res_w[vsew_i];

endmodule

/* source/valu_insn_queue.sv */
`timescale 1ns/100ps

module valu_insn_queue import valu_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  // New instructions
  input  valu_insn_t         insn_i,
  input  logic               insn_valid_i,
  output logic               insn_ready_o,
  // Head of the issue phase
  output valu_insn_t         issue_insn_o,
  output logic               issue_valid_o,
  input  logic               issue_done_i,
  // One granted word per beat
  input  logic               beat_i,
  output logic [NrVInsn-1:0] done_o
);

  typedef logic [$clog2(InsnQueueDepth)-1:0] pnt_t;
  typedef logic [$clog2(InsnQueueDepth):0]   cnt_t;

  // Instruction storage
  valu_insn_t [InsnQueueDepth-1:0] insn_q;

  // One pointer per phase
  pnt_t accept_pnt_q;
  pnt_t issue_pnt_q;
  pnt_t commit_pnt_q;

  // Instructions waiting for issue and for commit
  cnt_t issue_cnt_q;
  cnt_t commit_cnt_q;

  // Commit element tracking of the head instruction
  valu_insn_t commit_insn;
  logic       commit_busy_q;
  vl_t        commit_left_q;
  vl_t        commit_left;
  vl_t        commit_next;

  logic accept;
  logic retire;

  // Full once every slot waits for commit
  assign insn_ready_o = (commit_cnt_q != cnt_t'(InsnQueueDepth));
  assign accept       = insn_valid_i && insn_ready_o;

  assign issue_insn_o  = insn_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  //////////////////////////////////////////////////////////////////////
  // Commit tracking

  assign commit_insn = insn_q[commit_pnt_q];
  // A fresh head starts from its full vl
  assign commit_left = commit_busy_q ? commit_left_q : commit_insn.vl;
  assign commit_next = commit_left - word_elems(commit_insn.vsew, commit_left);
  // Last word of the head granted
  assign retire      = beat_i && (commit_next == '0);

  // Done pulses in the grant cycle
  always_comb begin
    done_o = '0;
    if (retire) begin
      done_o[commit_insn.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= insn_i;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q  <= '0;
      issue_pnt_q   <= '0;
      commit_pnt_q  <= '0;
      issue_cnt_q   <= '0;
      commit_cnt_q  <= '0;
      commit_busy_q <= 1'b0;
      commit_left_q <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (retire) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(retire);
      // Next head starts fresh after a retire
      if (beat_i) begin
        commit_busy_q <= !retire;
        commit_left_q <= commit_next;
      end
    end
  end

endmodule

/* source/valu_issue.sv */
`timescale 1ns/100ps

module valu_issue import valu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Instruction in its issue phase
  input  valu_insn_t insn_i,
  input  logic       insn_valid_i,
  output logic       issue_done_o,
  // Operand words
  input  operand_t   operand_i,
  input  logic       operand_valid_i,
  output logic       operand_ready_o,
  // Result queue write
  input  logic       full_i,
  output result_t    wr_o,
  output logic       wr_valid_o
);

  // Counters of the current instruction
  logic busy_q;
  vl_t  left_q;
  vl_t  widx_q;
  vl_t  left;
  vl_t  widx;
  vl_t  left_next;
  vl_t  elems;

  logic       accept;
  logic [3:0] nbytes;
  strb_t      be_valid;
  strb_t      be;
  elen_t      scalar_rep;
  elen_t      opa;
  elen_t      res;
  elen_t      wdata;

  //////////////////////////////////////////////////////////////////////
  // Element counting

  // First word uses vl straight from the queue, no load cycle
  assign left      = busy_q ? left_q : insn_i.vl;
  assign widx      = busy_q ? widx_q : '0;
  assign elems     = word_elems(insn_i.vsew, left);
  assign left_next = left - elems;

  assign operand_ready_o = insn_valid_i && !full_i;
  assign accept          = operand_ready_o && operand_valid_i;
  assign issue_done_o    = accept && (left_next == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      left_q <= '0;
      widx_q <= '0;
    end else if (accept) begin
      busy_q <= (left_next != '0);
      left_q <= left_next;
      widx_q <= widx + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operands and ALU

  // Scalar copied into every element
  always_comb begin
    unique case (insn_i.vsew)
      EW8:     scalar_rep = {8{insn_i.scalar[7:0]}};
      EW16:    scalar_rep = {4{insn_i.scalar[15:0]}};
      EW32:    scalar_rep = {2{insn_i.scalar[31:0]}};
      default: scalar_rep = insn_i.scalar;
    endcase
  end

  assign opa = insn_i.use_scalar ? scalar_rep : operand_i.a;

  valu_simd_alu i_simd_alu (
    .opa_i  (opa),
    .opb_i  (operand_i.b),
    .op_i   (insn_i.op),
    .vsew_i (insn_i.vsew),
    .res_o  (res)
  );

  //////////////////////////////////////////////////////////////////////
  // Byte enables and write data

  // Bytes covered by the valid elements of this word
  assign nbytes   = 4'(elems << insn_i.vsew);
  assign be_valid = strb_t'((9'h1 << nbytes) - 9'h1);
  // Mask ignored when unmasked
  assign be       = be_valid & (insn_i.vm ? '1 : operand_i.mask);

  // Disabled bytes carry zero
  always_comb begin
    for (int i = 0; i < StrbBits; i++) begin
      wdata[8*i +: 8] = be[i] ? res[8*i +: 8] : 8'h00;
    end
  end

  assign wr_o.id    = insn_i.id;
  assign wr_o.addr  = vaddr_t'(insn_i.vd) * vaddr_t'(VregWords) + vaddr_t'(widx);
  assign wr_o.wdata = wdata;
  assign wr_o.be    = be;
  assign wr_valid_o = accept;

endmodule

/* source/valu_result_queue.sv */
`timescale 1ns/100ps

module valu_result_queue import valu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Writes from issue
  input  result_t wr_i,
  input  logic    wr_valid_i,
  output logic    full_o,
  // Register file write port
  output result_t result_o,
  output logic    result_req_o,
  input  logic    result_gnt_i,
  // Grant seen by the instruction queue
  output logic    beat_o
);

  typedef logic [$clog2(ResultQueueDepth)-1:0] pnt_t;
  typedef logic [$clog2(ResultQueueDepth):0]   cnt_t;

  // Payload storage
  result_t [ResultQueueDepth-1:0] entry_q;

  pnt_t wr_pnt_q;
  pnt_t rd_pnt_q;
  cnt_t cnt_q;

  logic push;
  logic pop;

  assign full_o = (cnt_q == cnt_t'(ResultQueueDepth));
  // Issue already holds off when full
  assign push   = wr_valid_i && !full_o;

  // Head stays on the port until granted
  assign result_req_o = (cnt_q != '0);
  assign result_o     = entry_q[rd_pnt_q];
  assign pop          = result_req_o && result_gnt_i;
  assign beat_o       = pop;

  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_pnt_q] <= wr_i;
    end
  end

  // Push and pop may land in one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_pnt_q <= (wr_pnt_q == pnt_t'(ResultQueueDepth-1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= (rd_pnt_q == pnt_t'(ResultQueueDepth-1)) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + cnt_t'(push) - cnt_t'(pop);
    end
  end

endmodule

/* source/valu_top.sv */
`timescale 1ns/100ps

module valu_top import valu_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Instruction port
  input  valu_insn_t         insn_i,
  input  logic               insn_valid_i,
  output logic               insn_ready_o,
  // Operand port
  input  operand_t           operand_i,
  input  logic               operand_valid_i,
  output logic               operand_ready_o,
  // Register file port
  output result_t            result_o,
  output logic               result_req_o,
  input  logic               result_gnt_i,
  // Completion
  output logic [NrVInsn-1:0] done_o
);

  // Queue to issue
  valu_insn_t issue_insn;
  logic       issue_valid;
  logic       issue_done;

  // Issue to result queue
  result_t wr;
  logic    wr_valid;
  logic    full;

  // Granted words back to the queue
  logic beat;

  valu_insn_queue i_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .insn_ready_o  (insn_ready_o),
    .issue_insn_o  (issue_insn),
    .issue_valid_o (issue_valid),
    .issue_done_i  (issue_done),
    .beat_i        (beat),
    .done_o        (done_o)
  );

  valu_issue i_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (issue_insn),
    .insn_valid_i    (issue_valid),
    .issue_done_o    (issue_done),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .full_i          (full),
    .wr_o            (wr),
    .wr_valid_o      (wr_valid)
  );

  valu_result_queue i_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr_i         (wr),
    .wr_valid_i   (wr_valid),
    .full_o       (full),
    .result_o     (result_o),
    .result_req_o (result_req_o),
    .result_gnt_i (result_gnt_i),
    .beat_o       (beat)
  );

endmodule

/* verif/valu_assert.sv */
`timescale 1ns/100ps

module valu_assert import valu_pkg::*; (
  input logic               clk_i,
  input logic               rst_ni,
  input result_t            result_o,
  input logic               result_req_o,
  input logic               result_gnt_i,
  input logic               operand_ready_o,
  input logic [NrVInsn-1:0] done_o
);

  // A waiting request keeps its payload until the grant
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_o && !result_gnt_i |=> result_req_o && $stable(result_o))
    else $error("result request dropped or changed before its grant");

  // Outputs quiet during reset
  assert property (@(posedge clk_i)
    !rst_ni |-> !result_req_o && !operand_ready_o && (done_o == '0))
    else $error("request, operand ready or done active during reset");

  // At most one instruction finishes per cycle, and only on a grant
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(done_o) && ((done_o == '0) || (result_req_o && result_gnt_i)))
    else $error("done set without a grant or for more than one instruction");

endmodule

bind valu_top valu_assert i_valu_assert (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .result_o        (result_o),
  .result_req_o    (result_req_o),
  .result_gnt_i    (result_gnt_i),
  .operand_ready_o (operand_ready_o),
  .done_o          (done_o)
);

/* verif/valu_tb.sv */
`timescale 1ns/100ps

module valu_tb import valu_pkg::*; ();

  // Run length and grant stall bound
  localparam int unsigned NumInsn  = 80;
  localparam int unsigned MaxWords = VregWords;
  localparam int unsigned MaxStall = 4;
  // Each word waits at most MaxStall cycles for its grant, plus a few cycles per instruction
  localparam int unsigned TimeoutCycles = NumInsn * (MaxWords * (MaxStall + 1) + 4) + 100;

  logic               clk_i;
  logic               rst_ni;
  valu_insn_t         insn_i;
  logic               insn_valid_i;
  logic               insn_ready_o;
  operand_t           operand_i;
  logic               operand_valid_i;
  logic               operand_ready_o;
  result_t            result_o;
  logic               result_req_o;
  logic               result_gnt_i;
  logic [NrVInsn-1:0] done_o;

  // Separate LFSRs for stimulus and grants
  logic [31:0] stim_lfsr = 32'he71201a1;
  logic [31:0] gnt_lfsr  = 32'he71201a1;

  // Operand words waiting to be driven, and the model's expected writes
  operand_t    opnd_q[$];
  result_t     exp_res_q[$];
  logic        exp_last_q[$];
  string       exp_name_q[$];
  vid_t        next_id;
  int unsigned cycle_cnt = 0;
  int unsigned stall_cnt;

  valu_top dut_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (insn_i),
    .insn_valid_i    (insn_valid_i),
    .insn_ready_o    (insn_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .result_o        (result_o),
    .result_req_o    (result_req_o),
    .result_gnt_i    (result_gnt_i),
    .done_o          (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Random numbers and reference model

  // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rnd(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      v = {v[62:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  // Random vl that fits one register
  function automatic vl_t rand_vl(input vsew_e sew);
    return vl_t'(1 + (rnd(7) % (64 >> sew)));
  endfunction

  // Element mask of width w
  function automatic elen_t lane_mask(input int w);
    return (w == 64) ? {ElenBits{1'b1}} : ((64'd1 << w) - 64'd1);
  endfunction

  function automatic elen_t replicate(input vsew_e sew, input elen_t s);
    int    w;
    elen_t r;
    w = 8 << sew;
    r = '0;
    for (int e = 0; e < 64 / w; e++) begin
      r = r | ((s & lane_mask(w)) << (e * w));
    end
    return r;
  endfunction

  // Element by element, nothing crosses a lane
  function automatic elen_t model_word(input alu_op_e op, input vsew_e sew,
                                       input elen_t a, input elen_t b);
    int    w;
    elen_t x;
    elen_t y;
    elen_t z;
    elen_t r;
    w = 8 << sew;
    r = '0;
    for (int e = 0; e < 64 / w; e++) begin
      x = (a >> (e * w)) & lane_mask(w);
      y = (b >> (e * w)) & lane_mask(w);
      case (op)
        VADD:    z = x + y;
        VSUB:    z = x - y;
        VAND:    z = x & y;
        VOR:     z = x | y;
        VXOR:    z = x ^ y;
        VMINU:   z = (x < y) ? x : y;
        VMAXU:   z = (x > y) ? x : y;
        VSLL:    z = x << (y % w);
        default: z = '0;
      endcase
      r = r | ((z & lane_mask(w)) << (e * w));
    end
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [63:0] exp, input logic [63:0] act);
    assert (act == exp) else begin
      $display("ERR %s %s expected %h actual %h", test, field, exp, act);
      stop_on_error();
    end
  endtask

  // Build one instruction with its words, then hold it until accepted
  task automatic send_insn(input alu_op_e op, input vsew_e sew, input vl_t vl,
                           input logic use_scalar, input logic vm, input string name);
    valu_insn_t insn;
    operand_t   opnd;
    result_t    exp;
    elen_t      res;
    vl_t        left;
    int         per;
    int         elems;
    int         ebytes;
    logic [63:0] draw;
    logic       taken;
    insn.id         = next_id;
    insn.op         = op;
    insn.vsew       = sew;
    insn.vl         = vl;
    insn.vd         = vreg_t'(rnd(5));
    insn.use_scalar = use_scalar;
    insn.scalar     = rnd(64);
    insn.vm         = vm;
    next_id         = next_id + 3'd1;
    per    = 8 >> sew;
    ebytes = 1 << sew;
    left   = vl;
    for (int widx = 0; left != 0; widx++) begin
      elems     = (int'(left) < per) ? int'(left) : per;
      opnd.a    = rnd(64);
      opnd.b    = rnd(64);
      opnd.mask = '0;
      // One mask bit per element, spread over its bytes
      for (int e = 0; e < per; e++) begin
        draw = rnd(1);
        if (draw[0]) opnd.mask = opnd.mask | strb_t'(((1 << ebytes) - 1) << (e * ebytes));
      end
      res = model_word(op, sew, use_scalar ? replicate(sew, insn.scalar) : opnd.a, opnd.b);
      exp.id    = insn.id;
      exp.addr  = vaddr_t'(int'(insn.vd) * VregWords + widx);
      exp.be    = '0;
      exp.wdata = '0;
      for (int i = 0; i < StrbBits; i++) begin
        exp.be[i] = (i < elems * ebytes) && (vm || opnd.mask[i]);
        if (exp.be[i]) exp.wdata[8*i +: 8] = res[8*i +: 8];
      end
      left = left - vl_t'(elems);
      opnd_q.push_back(opnd);
      exp_res_q.push_back(exp);
      exp_last_q.push_back(left == '0);
      exp_name_q.push_back(name);
    end
    insn_i       = insn;
    insn_valid_i = 1'b1;
    taken        = 1'b0;
    while (!taken) begin
      #1;
      taken = insn_ready_o;
      @(negedge clk_i);
    end
    insn_valid_i = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Processes

  // Operand words in order, ready sampled after the falling edge
  initial begin
    operand_i       = '0;
    operand_valid_i = 1'b0;
    forever begin
      @(negedge clk_i);
      operand_valid_i = (opnd_q.size() != 0);
      if (operand_valid_i) operand_i = opnd_q[0];
      #1;
      if (operand_valid_i && operand_ready_o) void'(opnd_q.pop_front());
    end
  end

  // Random grants with bounded stall, handshakes against the model's occupancy
  initial begin
    result_t            exp;
    logic               last;
    string              name;
    logic [NrVInsn-1:0] exp_done;
    int                 insn_cnt;
    int                 issue_cnt;
    int                 rq_cnt;
    logic               insn_take;
    logic               opnd_take;
    logic               opnd_last;
    logic               granted;
    result_gnt_i = 1'b0;
    stall_cnt    = 0;
    insn_cnt     = 0;
    issue_cnt    = 0;
    rq_cnt       = 0;
    last         = 1'b0;
    forever begin
      @(negedge clk_i);
      gnt_lfsr     = lfsr_step(gnt_lfsr);
      result_gnt_i = gnt_lfsr[0] || (stall_cnt >= MaxStall);
      #1;
      stall_cnt = (result_req_o && !result_gnt_i) ? stall_cnt + 1 : 0;
      // Ready and request follow the queue occupancies
      check_value("handshake", "insn_ready",
                  64'(insn_cnt != InsnQueueDepth), 64'(insn_ready_o));
      check_value("handshake", "operand_ready",
                  64'((issue_cnt != 0) && (rq_cnt != ResultQueueDepth)), 64'(operand_ready_o));
      check_value("handshake", "result_req", 64'(rq_cnt != 0), 64'(result_req_o));
      insn_take = insn_valid_i && (insn_cnt != InsnQueueDepth);
      opnd_take = operand_valid_i && (issue_cnt != 0) && (rq_cnt != ResultQueueDepth);
      // Word taken now sits right behind those still in the result queue
      opnd_last = 1'b0;
      if (opnd_take) begin
        opnd_last = exp_last_q[rq_cnt];
      end
      granted  = (rq_cnt != 0) && result_gnt_i;
      exp_done = '0;
      name     = "no_grant";
      if (granted) begin
        exp  = exp_res_q.pop_front();
        last = exp_last_q.pop_front();
        name = exp_name_q.pop_front();
        check_value(name, "id", 64'(exp.id), 64'(result_o.id));
        check_value(name, "addr", 64'(exp.addr), 64'(result_o.addr));
        check_value(name, "be", 64'(exp.be), 64'(result_o.be));
        check_value(name, "wdata", exp.wdata, result_o.wdata);
        if (last) exp_done[exp.id] = 1'b1;
      end
      check_value(name, "done", 64'(exp_done), 64'(done_o));
      rq_cnt    = rq_cnt + int'(opnd_take) - int'(granted);
      issue_cnt = issue_cnt + int'(insn_take) - int'(opnd_last);
      insn_cnt  = insn_cnt + int'(insn_take) - int'(granted && last);
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    assert (cycle_cnt < TimeoutCycles) else begin
      $display("Timeout after %0d cycles, %0d results never arrived", cycle_cnt,
               exp_res_q.size());
      stop_on_error();
    end
  end

  initial begin
    vsew_e   sew;
    alu_op_e op;
    vl_t     vl;
    int      per;
    logic [63:0] flags;
    rst_ni       = 1'b0;
    insn_i       = '0;
    insn_valid_i = 1'b0;
    next_id      = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    // Every opcode at every width over a full register, unmasked
    for (int o = 0; o < 8; o++) begin
      for (int s = 0; s < 4; s++) begin
        send_insn(alu_op_e'(3'(o)), vsew_e'(2'(s)), vl_t'(64 >> s), 1'b0, 1'b1, "op_width");
      end
    end
    // Scalar in place of operand a
    for (int i = 0; i < 8; i++) begin
      sew = vsew_e'(2'(i));
      op  = alu_op_e'(3'(rnd(3)));
      vl  = rand_vl(sew);
      send_insn(op, sew, vl, 1'b1, 1'b1, "scalar");
    end
    // Element-uniform byte masks
    for (int i = 0; i < 8; i++) begin
      sew = vsew_e'(2'(rnd(2)));
      op  = alu_op_e'(3'(rnd(3)));
      vl  = rand_vl(sew);
      send_insn(op, sew, vl, 1'b0, 1'b0, "mask");
    end
    // Last word only partly filled
    for (int i = 0; i < 8; i++) begin
      sew = vsew_e'(2'(rnd(2) % 3));
      per = 8 >> sew;
      op  = alu_op_e'(3'(rnd(3)));
      vl  = vl_t'(rnd(3) * per);
      vl  = vl + vl_t'(1 + (rnd(3) % (per - 1)));
      send_insn(op, sew, vl, 1'b0, 1'b1, "partial_vl");
    end
    // Back to back with everything random
    for (int i = 0; i < 24; i++) begin
      sew   = vsew_e'(2'(rnd(2)));
      op    = alu_op_e'(3'(rnd(3)));
      vl    = rand_vl(sew);
      flags = rnd(2);
      send_insn(op, sew, vl, flags[1], flags[0], "stall_b2b");
    end
    while (exp_res_q.size() != 0) @(negedge clk_i);
    // Idle cycles still go through the handshake checks
    repeat (10) @(negedge clk_i);
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* valu_top.f */
source/valu_pkg.sv
source/valu_simd_alu.sv
source/valu_insn_queue.sv
source/valu_issue.sv
source/valu_result_queue.sv
source/valu_top.sv
verif/valu_assert.sv
verif/valu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the valu testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module valu_tb \
  -f valu_top.f --Mdir obj_dir -o valu_sim > build.log 2>&1 &&
{ ./obj_dir/valu_sim > sim.log 2>&1 || true; } &&
grep -q "^TEST PASSED$" sim.log &&
echo "simulation passed, see sim.log" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
